//--- Bender.yml
package:
  name: lsu_top

export_include_dirs:
  - .

sources:
  - lsu_pkg.sv
  - lsu_page_map.sv
  - lsu_value_unit.sv
  - lsu_data_mem.sv
  - lsu_ctrl.sv
  - lsu_top.sv
  - target: test
    files:
      - tb_lsu_top.sv

//--- lsu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defs.svh"

module lsu_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  lsu_pkg::lsu_req_t       req,
    output logic                    resp_valid,
    input  logic                    resp_ready,
    output lsu_pkg::lsu_resp_t      resp,
    output logic                    xlate_en,
    output logic                    is_write,
    output logic [`LSU_VADDR_W-1:0] vaddr,
    input  logic [`LSU_PADDR_W-1:0] paddr,
    input  logic                    xlate_fault,
    output logic                    mem_en,
    output lsu_pkg::mem_req_t       mem_req,
    input  logic [31:0]             load_value,
    output logic [31:0]             store_data,
    output lsu_pkg::lsu_size_e      store_size,
    output logic                    signed_ld,
    output logic [1:0]              byte_ofs,
    input  logic [31:0]             merged_data,
    input  logic [3:0]              byte_mask,
    input  logic [31:0]             mem_rdata,
    input  logic                    sc_fail
);

    typedef enum logic [2:0] {
        st_idle      = 3'd0,
        st_translate = 3'd1,
        st_read      = 3'd2,
        st_calc      = 3'd3,
        st_write     = 3'd4,
        st_respond   = 3'd5
    } state_e;

    state_e             state;
    lsu_pkg::lsu_req_t  req_q;
    logic [31:0]        addr_q;
    logic [31:0]        old_q;
    logic [31:0]        amo_res;
    logic               is_amo;
    logic               is_st;
    logic               resp_load;
    lsu_pkg::lsu_resp_t resp_next;

    function automatic logic [31:0] amo_alu(lsu_pkg::amo_op_e op, logic [31:0] src,
                                            logic [31:0] old);
        case (op)
            lsu_pkg::amo_swap: return src;
            lsu_pkg::amo_add:  return src + old;
            lsu_pkg::amo_xor:  return src ^ old;
            lsu_pkg::amo_and:  return src & old;
            lsu_pkg::amo_or:   return src | old;
            lsu_pkg::amo_min:  return ($signed(src) < $signed(old)) ? src : old;
            lsu_pkg::amo_max:  return ($signed(src) > $signed(old)) ? src : old;
            lsu_pkg::amo_minu: return (src < old) ? src : old;
            lsu_pkg::amo_maxu: return (src > old) ? src : old;
            default:           return old;
        endcase
    endfunction

    assign is_amo = req_q.cmd == lsu_pkg::cmd_amo;
    assign is_st  = req_q.cmd inside {lsu_pkg::cmd_store, lsu_pkg::cmd_sc};

    assign req_ready = (state == st_idle) && !resp_valid;
    assign xlate_en  = state == st_translate;
    assign is_write  = is_st || is_amo;
    assign vaddr     = addr_q[`LSU_VADDR_W-1:0];

    // Faulting commands never reach memory
    assign mem_en = (state == st_read || state == st_write) && !xlate_fault;

    always_comb begin
        mem_req         = '0;
        mem_req.idx     = paddr[`LSU_PADDR_W-1:2];
        mem_req.we      = state == st_write;
        mem_req.mask    = byte_mask;
        mem_req.wdata   = merged_data;
        mem_req.reserve = (state == st_read) && (req_q.cmd == lsu_pkg::cmd_lr);
        mem_req.cond    = (state == st_write) && (req_q.cmd == lsu_pkg::cmd_sc);
    end

    // Atomics always move a whole aligned word
    assign store_data = is_amo ? amo_res : req_q.rs2;
    assign store_size = is_amo ? lsu_pkg::size_word : req_q.op.mem.size;
    assign signed_ld  = req_q.op.mem.is_signed;
    assign byte_ofs   = is_amo ? 2'b00 : addr_q[1:0];

    always_comb begin
        resp_next       = '0;
        resp_next.vaddr = (req_q.cmd == lsu_pkg::cmd_none) ? 32'd0 : addr_q;
        resp_load       = 1'b0;
        case (state)
            st_read, st_write: begin
                if (xlate_fault) begin
                    resp_load             = 1'b1;
                    resp_next.store_fault = is_st;
                    resp_next.load_fault  = !is_st;
                end
            end
            st_respond: begin
                resp_load = 1'b1;
                case (req_q.cmd)
                    lsu_pkg::cmd_load, lsu_pkg::cmd_lr: resp_next.data = load_value;
                    lsu_pkg::cmd_amo:                   resp_next.data = old_q;
                    lsu_pkg::cmd_sc:                    resp_next.data = {31'd0, sc_fail};
                    default:                            resp_next.data = 32'd0;
                endcase
            end
            default: begin
                resp_load = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_idle;
            resp_valid <= 1'b0;
        end else begin
            if (resp_load) begin
                resp_valid <= 1'b1;
            end else if (resp_ready) begin
                resp_valid <= 1'b0;
            end
            case (state)
                st_idle: begin
                    if (req_valid && req_ready) begin
                        state <= (req.cmd == lsu_pkg::cmd_none) ? st_respond : st_translate;
                    end
                end
                st_translate: state <= is_st ? st_write : st_read;
                st_read:      state <= xlate_fault ? st_idle : (is_amo ? st_calc : st_respond);
                st_calc:      state <= st_write;
                st_write:     state <= xlate_fault ? st_idle : st_respond;
                default:      state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_q  <= req;
            addr_q <= req.rs1 + {{20{req.imm[11]}}, req.imm};
        end
        if (state == st_calc) begin
            old_q   <= mem_rdata;
            amo_res <= amo_alu(req_q.op.amo.op, req_q.rs2, mem_rdata);
        end
        if (resp_load) begin
            resp <= resp_next;
        end
    end

    // Every memory access leads on to calc or respond
    assert property (@(posedge clk) disable iff (rst) mem_en |=> state != st_idle);

    assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp));

endmodule

`default_nettype wire

//--- lsu_data_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defs.svh"

module lsu_data_mem (
    input  logic              clk,
    input  logic              rst,
    input  logic              mem_en,
    input  lsu_pkg::mem_req_t mem_req,
    output logic [31:0]       rdata,
    output logic              sc_fail
);

    logic [31:0]               mem [`LSU_MEM_WORDS];
    logic                      resv_valid;
    logic [`LSU_MEM_IDX_W-1:0] resv_idx;
    logic                      sc_ok;
    logic                      do_write;

    assign sc_ok = resv_valid && (resv_idx == mem_req.idx);

    // A failed store-conditional leaves the word alone
    assign do_write = mem_en && mem_req.we && (!mem_req.cond || sc_ok);

    always_ff @(posedge clk) begin
        if (mem_en) begin
            rdata <= mem[mem_req.idx];
        end
        if (do_write) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_req.mask[b]) begin
                    mem[mem_req.idx][8*b +: 8] <= mem_req.wdata[8*b +: 8];
                end
            end
        end
    end

    // Single reservation
    always_ff @(posedge clk) begin
        if (rst) begin
            resv_valid <= 1'b0;
            sc_fail    <= 1'b0;
        end else if (mem_en) begin
            sc_fail <= mem_req.cond && !sc_ok;
            if (mem_req.reserve) begin
                resv_valid <= 1'b1;
                resv_idx   <= mem_req.idx;
            end else if (mem_req.we && (mem_req.cond || mem_req.idx == resv_idx)) begin
                // Any sc, or a store hitting the reserved word
                resv_valid <= 1'b0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        mem_en |-> !(mem_req.reserve && mem_req.cond));

endmodule

`default_nettype wire

//--- lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Virtual space is eight pages of 256 bytes
`define LSU_VADDR_W 11
`define LSU_PAGE_OFS_W 8
`define LSU_VPN_W 3

// Physical space is four pages, 1 KB in all
`define LSU_PPN_W 2
`define LSU_PADDR_W (`LSU_PPN_W + `LSU_PAGE_OFS_W)

// Word-wide data memory
`define LSU_MEM_WORDS 256
`define LSU_MEM_IDX_W ($clog2(`LSU_MEM_WORDS))

`endif

//--- lsu_golden.txt
# C vpn entry, entry = {valid, writable, ppn[1:0]} in hex
# T name cmd op rs1 imm rs2 exp_data exp_load_fault exp_store_fault, all hex
C 0 c
C 1 d
C 2 9
C 3 c
C 5 e
T sw_init 2 04 00000040 000 11223344 00000000 0 0
T sb_ofs1 2 00 00000040 001 000000a5 00000000 0 0
T lb_signed 1 01 00000040 001 00000000 ffffffa5 0 0
T lbu 1 00 00000040 001 00000000 000000a5 0 0
T sh_ofs2 2 02 00000040 002 00008001 00000000 0 0
T lh_signed 1 03 00000040 002 00000000 ffff8001 0 0
T lhu 1 02 00000040 002 00000000 00008001 0 0
T lb_pos 1 01 00000040 000 00000000 00000044 0 0
T lw_negimm 1 04 00000050 ff0 00000000 8001a544 0 0
T nop 0 00 00000123 000 00000000 00000000 0 0
T sw_amo 2 04 00000080 000 00000010 00000000 0 0
T amo_swap 3 00 00000080 000 00000005 00000010 0 0
T amo_add 3 02 00000080 000 fffffffe 00000005 0 0
T amo_xor 3 04 00000080 000 0000000f 00000003 0 0
T amo_and 3 06 00000080 000 00000006 0000000c 0 0
T amo_or 3 08 00000080 000 f0000000 00000004 0 0
T amo_min 3 0a 00000080 000 00000001 f0000004 0 0
T amo_max 3 0c 00000080 000 00000007 f0000004 0 0
T amo_minu 3 0e 00000080 000 fffffff0 00000007 0 0
T amo_maxu 3 10 00000080 000 90000000 00000007 0 0
T lw_amo 1 04 00000080 000 00000000 90000000 0 0
T sw_resv 2 04 000000c0 000 00000001 00000000 0 0
T lr_first 4 04 000000c0 000 00000000 00000001 0 0
T sc_ok 5 04 000000c0 000 000000aa 00000000 0 0
T lw_sc_ok 1 04 000000c0 000 00000000 000000aa 0 0
T sc_again 5 04 000000c0 000 000000bb 00000001 0 0
T lw_sc_again 1 04 000000c0 000 00000000 000000aa 0 0
T lr_second 4 04 000000c0 000 00000000 000000aa 0 0
T sw_between 2 04 000000c0 000 000000cc 00000000 0 0
T sc_after_sw 5 04 000000c0 000 000000dd 00000001 0 0
T lw_after_sc 1 04 000000c0 000 00000000 000000cc 0 0
T ld_invalid 1 04 00000400 000 00000000 00000000 1 0
T sc_invalid 5 04 00000410 000 00000001 00000000 0 1
T sw_rw_view 2 04 00000140 000 5a5a5a5a 00000000 0 0
T sw_ro_page 2 04 00000240 000 12345678 00000000 0 1
T amo_ro_page 3 02 00000240 000 00000001 00000000 1 0
T lw_ro_page 1 04 00000240 000 00000000 5a5a5a5a 0 0
T sw_alias 2 04 00000388 000 cafef00d 00000000 0 0
T lw_alias 1 04 00000088 000 00000000 cafef00d 0 0
T sw_page5 2 04 00000588 000 11111111 00000000 0 0
T lw_alias_kept 1 04 00000388 000 00000000 cafef00d 0 0

//--- lsu_page_map.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defs.svh"

module lsu_page_map (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cfg_we,
    input  logic [`LSU_VPN_W-1:0]     cfg_index,
    input  lsu_pkg::page_entry_t      cfg_entry,
    input  logic                      xlate_en,
    input  logic                      is_write,
    input  logic [`LSU_VADDR_W-1:0]   vaddr,
    output logic [`LSU_PADDR_W-1:0]   paddr,
    output logic                      fault
);

    lsu_pkg::page_entry_t entries [1 << `LSU_VPN_W];
    lsu_pkg::page_entry_t hit;

    // Upper address bits select the entry
    assign hit = entries[vaddr[`LSU_VADDR_W-1 -: `LSU_VPN_W]];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < (1 << `LSU_VPN_W); i++) begin
                entries[i] <= '0;
            end
        end else if (cfg_we) begin
            entries[cfg_index] <= cfg_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fault <= 1'b0;
        end else if (xlate_en) begin
            fault <= !hit.valid || (is_write && !hit.writable);
        end
    end

    always_ff @(posedge clk) begin
        if (xlate_en) begin
            paddr <= {hit.ppn, vaddr[`LSU_PAGE_OFS_W-1:0]};
        end
    end

    // Map is only rewritten while no command is translating
    assert property (@(posedge clk) disable iff (rst) !(cfg_we && xlate_en));

endmodule

`default_nettype wire

//--- lsu_pkg.sv
`default_nettype none
`include "lsu_defs.svh"

package lsu_pkg;

    typedef enum logic [2:0] {
        cmd_none  = 3'd0,
        cmd_load  = 3'd1,
        cmd_store = 3'd2,
        cmd_amo   = 3'd3,
        cmd_lr    = 3'd4,
        cmd_sc    = 3'd5
    } lsu_cmd_e;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } lsu_size_e;

    typedef enum logic [3:0] {
        amo_swap = 4'd0,
        amo_add  = 4'd1,
        amo_xor  = 4'd2,
        amo_and  = 4'd3,
        amo_or   = 4'd4,
        amo_min  = 4'd5,
        amo_max  = 4'd6,
        amo_minu = 4'd7,
        amo_maxu = 4'd8
    } amo_op_e;

    typedef struct packed {
        logic [1:0] pad;
        lsu_size_e  size;
        logic       is_signed;
    } mem_op_t;

    typedef struct packed {
        amo_op_e op;
        logic    pad;
    } amo_view_t;

    // mem view for load, store, lr and sc; amo view for cmd_amo
    typedef union packed {
        mem_op_t   mem;
        amo_view_t amo;
    } lsu_op_u;

    typedef struct packed {
        lsu_cmd_e    cmd;
        lsu_op_u     op;
        logic [31:0] rs1;
        logic [11:0] imm;
        logic [31:0] rs2;
    } lsu_req_t;

    typedef struct packed {
        logic [31:0] data;
        logic [31:0] vaddr;
        logic        load_fault;
        logic        store_fault;
    } lsu_resp_t;

    typedef struct packed {
        logic                  valid;
        logic                  writable;
        logic [`LSU_PPN_W-1:0] ppn;
    } page_entry_t;

    typedef struct packed {
        logic [`LSU_MEM_IDX_W-1:0] idx;
        logic                      we;
        logic [3:0]                mask;
        logic [31:0]               wdata;
        logic                      reserve;
        logic                      cond;
    } mem_req_t;

endpackage

`default_nettype wire

//--- lsu_top.f
+incdir+.
lsu_pkg.sv
lsu_page_map.sv
lsu_value_unit.sv
lsu_data_mem.sv
lsu_ctrl.sv
lsu_top.sv
tb_lsu_top.sv

//--- lsu_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defs.svh"

module lsu_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  lsu_pkg::lsu_req_t    req,
    output logic                 resp_valid,
    input  logic                 resp_ready,
    output lsu_pkg::lsu_resp_t   resp,
    input  logic                 cfg_we,
    input  logic [`LSU_VPN_W-1:0] cfg_index,
    input  lsu_pkg::page_entry_t cfg_entry
);

    logic                    xlate_en;
    logic                    is_write;
    logic [`LSU_VADDR_W-1:0] vaddr;
    logic [`LSU_PADDR_W-1:0] paddr;
    logic                    xlate_fault;
    logic                    mem_en;
    lsu_pkg::mem_req_t       mem_req;
    logic [31:0]             load_value;
    logic [31:0]             store_data;
    lsu_pkg::lsu_size_e      store_size;
    logic                    signed_ld;
    logic [1:0]              byte_ofs;
    logic [31:0]             merged_data;
    logic [3:0]              byte_mask;
    logic [31:0]             mem_rdata;
    logic                    sc_fail;

    lsu_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req         (req),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .resp        (resp),
        .xlate_en    (xlate_en),
        .is_write    (is_write),
        .vaddr       (vaddr),
        .paddr       (paddr),
        .xlate_fault (xlate_fault),
        .mem_en      (mem_en),
        .mem_req     (mem_req),
        .load_value  (load_value),
        .store_data  (store_data),
        .store_size  (store_size),
        .signed_ld   (signed_ld),
        .byte_ofs    (byte_ofs),
        .merged_data (merged_data),
        .byte_mask   (byte_mask),
        .mem_rdata   (mem_rdata),
        .sc_fail     (sc_fail)
    );

    lsu_page_map u_page_map (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_index (cfg_index),
        .cfg_entry (cfg_entry),
        .xlate_en  (xlate_en),
        .is_write  (is_write),
        .vaddr     (vaddr),
        .paddr     (paddr),
        .fault     (xlate_fault)
    );

    // Same size drives both the load and the store side
    lsu_value_unit u_value (
        .size        (store_size),
        .signed_ld   (signed_ld),
        .byte_ofs    (byte_ofs),
        .rdata       (mem_rdata),
        .load_value  (load_value),
        .store_data  (store_data),
        .merged_data (merged_data),
        .byte_mask   (byte_mask)
    );

    lsu_data_mem u_mem (
        .clk     (clk),
        .rst     (rst),
        .mem_en  (mem_en),
        .mem_req (mem_req),
        .rdata   (mem_rdata),
        .sc_fail (sc_fail)
    );

endmodule

`default_nettype wire

//--- lsu_value_unit.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_value_unit (
    input  lsu_pkg::lsu_size_e size,
    input  logic               signed_ld,
    input  logic [1:0]         byte_ofs,
    input  logic [31:0]        rdata,
    output logic [31:0]        load_value,
    input  logic [31:0]        store_data,
    output logic [31:0]        merged_data,
    output logic [3:0]         byte_mask
);

    logic [4:0]  shamt;
    logic [63:0] rd_rot;
    logic [31:0] rd_sh;
    logic [63:0] wd_rot;
    logic [3:0]  mask_base;
    logic [7:0]  mask_rot;

    assign shamt = {byte_ofs, 3'b000};

    // Rotate right so the addressed byte sits in lane 0
    assign rd_rot = {rdata, rdata} >> shamt;
    assign rd_sh  = rd_rot[31:0];

    always_comb begin
        case (size)
            lsu_pkg::size_byte: begin
                load_value = {{24{signed_ld & rd_sh[7]}}, rd_sh[7:0]};
            end
            lsu_pkg::size_half: begin
                load_value = {{16{signed_ld & rd_sh[15]}}, rd_sh[15:0]};
            end
            default: begin
                load_value = rd_sh;
            end
        endcase
    end

    // Store side rotates left, lanes wrap within the word
    assign wd_rot      = {store_data, store_data} << shamt;
    assign merged_data = wd_rot[63:32];

    always_comb begin
        case (size)
            lsu_pkg::size_byte: mask_base = 4'b0001;
            lsu_pkg::size_half: mask_base = 4'b0011;
            default:            mask_base = 4'b1111;
        endcase
    end

    assign mask_rot  = {mask_base, mask_base} << byte_ofs;
    assign byte_mask = mask_rot[7:4];

endmodule

`default_nettype wire

//--- tb_lsu_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defs.svh"

module tb_lsu_top;

    localparam int RESET_CYCLES    = 10;
    localparam int CYCLES_PER_TEST = 20;

    typedef struct packed {
        logic [`LSU_VPN_W-1:0] index;
        lsu_pkg::page_entry_t  entry;
    } cfg_rec_t;

    typedef struct packed {
        logic [8*24-1:0] name;
        logic [2:0]      cmd;
        logic [4:0]      op;
        logic [31:0]     rs1;
        logic [11:0]     imm;
        logic [31:0]     rs2;
        logic [31:0]     exp_data;
        logic            exp_lfault;
        logic            exp_sfault;
    } test_rec_t;

    logic                  clk;
    logic                  rst;
    logic                  req_valid;
    logic                  req_ready;
    lsu_pkg::lsu_req_t     req;
    logic                  resp_valid;
    logic                  resp_ready;
    lsu_pkg::lsu_resp_t    resp;
    logic                  cfg_we;
    logic [`LSU_VPN_W-1:0] cfg_index;
    lsu_pkg::page_entry_t  cfg_entry;

    cfg_rec_t  cfgs [$];
    test_rec_t tests [$];
    integer    seed;
    int        cycles;
    int        cycle_limit;
    int        errors;
    int        tests_failed;
    bit        file_ok;

    lsu_top UUT (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp),
        .cfg_we     (cfg_we),
        .cfg_index  (cfg_index),
        .cfg_entry  (cfg_entry)
    );

    always #2 clk = ~clk;

    // Random back-pressure with ready about three cycles in four
    always @(posedge clk) begin
        #1;
        resp_ready = ($random(seed) & 3) != 0;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("ERROR: timeout, the run took more than %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic read_golden();
        int               fd;
        int               code;
        logic [8*8-1:0]   tag;
        logic [8*24-1:0]  name;
        logic [8*128-1:0] line;
        logic [31:0]      fld [8];
        cfg_rec_t         c;
        test_rec_t        t;

        fd = $fopen("lsu_golden.txt", "r");
        file_ok = fd != 0;
        if (file_ok) begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", tag);
                if (code != 1) begin
                    break;
                end
                if (tag == "#") begin
                    code = $fgets(line, fd);
                end else if (tag == "C") begin
                    code = $fscanf(fd, "%h %h", fld[0], fld[1]);
                    c.index = fld[0][`LSU_VPN_W-1:0];
                    c.entry = fld[1][3:0];
                    cfgs.push_back(c);
                end else if (tag == "T") begin
                    code = $fscanf(fd, "%s %h %h %h %h %h %h %h %h", name, fld[0], fld[1],
                                   fld[2], fld[3], fld[4], fld[5], fld[6], fld[7]);
                    if (code != 9) begin
                        $display("ERROR: malformed test record in the golden file");
                        errors++;
                        break;
                    end
                    t.name       = name;
                    t.cmd        = fld[0][2:0];
                    t.op         = fld[1][4:0];
                    t.rs1        = fld[2];
                    t.imm        = fld[3][11:0];
                    t.rs2        = fld[4];
                    t.exp_data   = fld[5];
                    t.exp_lfault = fld[6][0];
                    t.exp_sfault = fld[7][0];
                    tests.push_back(t);
                end else begin
                    $display("ERROR: unknown record type in the golden file");
                    errors++;
                    break;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_config();
        foreach (cfgs[i]) begin
            @(posedge clk);
            #1;
            cfg_we    = 1'b1;
            cfg_index = cfgs[i].index;
            cfg_entry = cfgs[i].entry;
        end
        @(posedge clk);
        #1;
        cfg_we = 1'b0;
    endtask

    task automatic run_test(input test_rec_t t);
        lsu_pkg::lsu_resp_t got;
        logic [31:0]        exp_vaddr;
        logic signed [31:0] imm_ext;
        bit                 accepted;
        bit                 answered;
        bit                 first;
        int                 errors_before;

        errors_before = errors;
        imm_ext       = $signed(t.imm);
        // Base plus sign-extended offset and zero for a none command
        if (t.cmd == 3'd0) begin
            exp_vaddr = 32'd0;
        end else begin
            exp_vaddr = t.rs1 + imm_ext;
        end

        @(posedge clk);
        #1;
        req_valid = 1'b1;
        req       = {t.cmd, t.op, t.rs1, t.imm, t.rs2};
        accepted  = 1'b0;
        first     = 1'b1;
        while (!accepted) begin
            @(negedge clk);
            if (first && resp_valid) begin
                $display("ERROR: t=%0t response pending before %0s was issued", $time, t.name);
                errors++;
            end
            first    = 1'b0;
            accepted = req_ready;
            @(posedge clk);
        end
        #1;
        req_valid = 1'b0;
        req       = '0;

        answered = 1'b0;
        while (!answered) begin
            @(negedge clk);
            if (resp_valid && resp_ready) begin
                got      = resp;
                answered = 1'b1;
            end
            @(posedge clk);
        end

        if (got.data !== t.exp_data) begin
            $display("CHECK FAILED t=%0t resp.data expected %h got %h",
                     $time, t.exp_data, got.data);
            errors++;
        end
        if (got.vaddr !== exp_vaddr) begin
            $display("CHECK FAILED t=%0t resp.vaddr expected %h got %h",
                     $time, exp_vaddr, got.vaddr);
            errors++;
        end
        if (got.load_fault !== t.exp_lfault) begin
            $display("CHECK FAILED t=%0t resp.load_fault expected %b got %b",
                     $time, t.exp_lfault, got.load_fault);
            errors++;
        end
        if (got.store_fault !== t.exp_sfault) begin
            $display("CHECK FAILED t=%0t resp.store_fault expected %b got %b",
                     $time, t.exp_sfault, got.store_fault);
            errors++;
        end

        if (errors == errors_before) begin
            $display("PASS %0s", t.name);
        end else begin
            $display("FAIL %0s", t.name);
            tests_failed++;
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        resp_ready   = 1'b0;
        cfg_we       = 1'b0;
        cfg_index    = '0;
        cfg_entry    = '0;
        seed         = 32'h8b130343;
        cycles       = 0;
        cycle_limit  = 1000;
        errors       = 0;
        tests_failed = 0;

        read_golden();
        cycle_limit = RESET_CYCLES + 2 * cfgs.size() + CYCLES_PER_TEST * tests.size() + 8;

        if (!file_ok) begin
            $display("ERROR: cannot open lsu_golden.txt");
            $display("Simulation failed");
            $finish;
        end else begin
            repeat (RESET_CYCLES) @(posedge clk);
            #1;
            rst = 1'b0;
            apply_config();
            foreach (tests[k]) begin
                run_test(tests[k]);
            end
            // Nothing may answer once every command is done
            repeat (4) begin
                @(negedge clk);
                if (resp_valid) begin
                    $display("ERROR: t=%0t response raised with no command in flight", $time);
                    errors++;
                end
            end
            $display("Tests: %0d run, %0d passed, %0d failed, %0d errors",
                     tests.size(), tests.size() - tests_failed, tests_failed, errors);
            if (errors == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire
